// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_ntt_ctrl
RTL_TOP    ?= ntt_ctrl_top
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall

RTL_SRCS ?= design/ntt_cfg_pkg.sv \
            design/ntt_ctrl_pkg.sv \
            design/butterfly_counter.sv \
            design/stage_sequencer.sv \
            design/control_decoder.sv \
            design/ntt_ctrl_top.sv
TB_SRCS  ?= verification/tb_ntt_ctrl.sv

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD_DIR)

// ==== design/butterfly_counter.sv ====
`timescale 1ns/1ns

module butterfly_counter (
    input  logic                    clk,
    input  logic                    rst,
    input  ntt_ctrl_pkg::ntt_state_t state,
    input  ntt_ctrl_pkg::ite_idx_t  ite_idx,
    input  logic                    operand_valid,
    output logic                    group_end,
    output logic                    ite_end
);

    logic                issue;
    ntt_cfg_pkg::depth_t bu_cnt;
    ntt_cfg_pkg::depth_t grp_cnt;
    ntt_cfg_pkg::depth_t limit;
    ntt_cfg_pkg::depth_t group_len;

    // a butterfly goes out whenever operands are there during an iteration
    assign issue = (state == ntt_ctrl_pkg::ST_ITE) && operand_valid;

    always_comb begin
        if (ite_idx == ntt_ctrl_pkg::LAST_ITE) begin
            limit = ntt_cfg_pkg::BU_TOTAL_K2;
        end else begin
            limit = ntt_cfg_pkg::BU_TOTAL;
        end
        group_len = ntt_cfg_pkg::GROUP_LEN[ite_idx];
    end

    assign ite_end   = issue && (bu_cnt == limit - 1'b1);
    assign group_end = issue && (grp_cnt == group_len - 1'b1);

    // issued butterflies in this iteration
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bu_cnt <= '0;
        end else if (state != ntt_ctrl_pkg::ST_ITE) begin
            bu_cnt <= '0;
        end else if (issue) begin
            bu_cnt <= bu_cnt + 1'b1;
        end
    end

    // position inside the current twiddle group
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            grp_cnt <= '0;
        end else if (state != ntt_ctrl_pkg::ST_ITE) begin
            grp_cnt <= '0;
        end else if (group_end) begin
            grp_cnt <= '0;
        end else if (issue) begin
            grp_cnt <= grp_cnt + 1'b1;
        end
    end

    // sequencer must leave ITE on the edge that completes the iteration
    a_cnt_below_limit : assert property (
        @(posedge clk) disable iff (rst)
        (state == ntt_ctrl_pkg::ST_ITE) |-> (bu_cnt < limit)
    );

endmodule

// ==== design/control_decoder.sv ====
`timescale 1ns/1ns

module control_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  ntt_ctrl_pkg::ntt_state_t state,
    input  ntt_ctrl_pkg::ite_idx_t   ite_idx,
    input  logic                     group_end,
    input  logic                     ite_end,
    input  logic                     operand_valid,
    input  logic                     read_done,
    input  logic                     bu_done,
    output logic                     tf_init_base,
    output logic                     tf_init_const,
    output logic                     tf_ren,
    output logic                     tf_wen,
    output ntt_cfg_pkg::depth_t      tf_depth,
    output logic                     agu_enable,
    output logic                     agu_enable_k2,
    output logic                     r_enable,
    output logic                     w_enable,
    output logic                     ntt_enable,
    output logic                     last_stage,
    output logic                     finished
);

    logic                is_ite0;
    logic                is_last;
    logic                pat_step;
    ntt_cfg_pkg::depth_t agu_cnt;
    logic [1:0]          pat_cnt;
    ntt_cfg_pkg::depth_t ite_depth;

    assign is_ite0  = (state == ntt_ctrl_pkg::ST_ITE) && (ite_idx == 2'd0);
    assign is_last  = ite_idx == ntt_ctrl_pkg::LAST_ITE;
    assign pat_step = (state == ntt_ctrl_pkg::ST_ITE) && (ite_idx == 2'd2) && operand_valid;

    // agu run length in iteration 0, saturates
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            agu_cnt <= '0;
        end else if (!is_ite0) begin
            agu_cnt <= '0;
        end else if (agu_cnt != ntt_cfg_pkg::AGU_RUN_0) begin
            agu_cnt <= agu_cnt + 1'b1;
        end
    end

    // wraps every four issues, so it is back at zero after iteration 2
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pat_cnt <= '0;
        end else if (pat_step) begin
            pat_cnt <= pat_cnt + 2'd1;
        end
    end

    // depth seen by the twiddle generator on an issue
    always_comb begin
        case (ite_idx)
            2'd2: begin
                // 2, 3, 3, 2
                ite_depth = ntt_cfg_pkg::depth_t'(ite_idx)
                          + ntt_cfg_pkg::depth_t'(pat_cnt[1] ^ pat_cnt[0]);
            end
            ntt_ctrl_pkg::LAST_ITE: begin
                ite_depth = ntt_cfg_pkg::LAST_DEPTH;
            end
            default: begin
                ite_depth = ntt_cfg_pkg::depth_t'(ite_idx);
            end
        endcase
    end

    always_comb begin
        tf_init_base  = 1'b0;
        tf_init_const = 1'b0;
        tf_ren        = 1'b0;
        tf_wen        = 1'b0;
        tf_depth      = '0;
        agu_enable    = 1'b0;
        agu_enable_k2 = 1'b0;
        r_enable      = 1'b0;
        w_enable      = 1'b0;
        ntt_enable    = 1'b0;
        last_stage    = 1'b0;
        finished      = 1'b0;
        case (state)
            ntt_ctrl_pkg::ST_IDLE: begin
                tf_init_base  = 1'b1;
                tf_init_const = 1'b1;
            end
            ntt_ctrl_pkg::ST_ITE: begin
                r_enable   = operand_valid;
                tf_ren     = operand_valid;
                w_enable   = bu_done;
                ntt_enable = read_done;
                if (operand_valid) begin
                    tf_depth = ite_depth;
                end
                // the final group end needs no new twiddle
                tf_wen = (ite_idx != 2'd0) && group_end && !ite_end;
                if (ite_idx == 2'd0) begin
                    agu_enable = agu_cnt != ntt_cfg_pkg::AGU_RUN_0;
                end else begin
                    agu_enable = !is_last;
                end
                agu_enable_k2 = is_last;
                last_stage    = is_last;
            end
            ntt_ctrl_pkg::ST_DRAIN: begin
                w_enable   = 1'b1;
                ntt_enable = read_done;
                if (is_last) begin
                    tf_depth = ntt_cfg_pkg::LAST_DEPTH;
                end else begin
                    tf_depth = ntt_cfg_pkg::depth_t'(ite_idx);
                end
                last_stage = is_last;
            end
            ntt_ctrl_pkg::ST_FINISH: begin
                finished = 1'b1;
            end
            default: begin
            end
        endcase
    end

    a_read_only_in_ite : assert property (
        @(posedge clk) disable iff (rst)
        r_enable |-> (state == ntt_ctrl_pkg::ST_ITE)
    );

endmodule

// ==== design/ntt_cfg_pkg.sv ====
package ntt_cfg_pkg;

    // counter and depth width
    localparam int unsigned D_WIDTH = 8;

    typedef logic [D_WIDTH-1:0] depth_t;

    // cycles spent in idle while the twiddle generator loads base and constant
    localparam depth_t INIT_CYCLES = 8'd16;

    // butterflies issued per iteration
    localparam depth_t BU_TOTAL    = 8'd32;
    localparam depth_t BU_TOTAL_K2 = 8'd16;

    // butterflies sharing one twiddle factor, per iteration
    localparam depth_t GROUP_LEN [4] = '{
        8'd32,
        8'd2,
        8'd16,
        8'd4
    };

    // write-back drain after each iteration
    // last iteration has a shorter pipeline tail
    localparam depth_t DRAIN_LEN [4] = '{
        8'd13,
        8'd13,
        8'd13,
        8'd3
    };

    // address generator run length in iteration 0
    localparam depth_t AGU_RUN_0 = 8'd32;

    // twiddle depth held through the last iteration
    localparam depth_t LAST_DEPTH = 8'd4;

endpackage

// ==== design/ntt_ctrl_pkg.sv ====
package ntt_ctrl_pkg;

    // ITE and DRAIN are qualified by the iteration index
    typedef enum logic [2:0] {
        ST_RESET,
        ST_IDLE,
        ST_ITE,
        ST_DRAIN,
        ST_FINISH
    } ntt_state_t;

    // four butterfly iterations
    typedef logic [1:0] ite_idx_t;

    // radix-k2 iteration, the only one with a reduced butterfly count
    localparam ite_idx_t LAST_ITE = 2'd3;

endpackage

// ==== design/ntt_ctrl_top.sv ====
`timescale 1ns/1ns

module ntt_ctrl_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                operand_valid,
    input  logic                read_done,
    input  logic                bu_done,
    output logic                tf_init_base,
    output logic                tf_init_const,
    output logic                tf_ren,
    output logic                tf_wen,
    output ntt_cfg_pkg::depth_t tf_depth,
    output logic                agu_enable,
    output logic                agu_enable_k2,
    output logic                r_enable,
    output logic                w_enable,
    output logic                ntt_enable,
    output logic                last_stage,
    output logic                finished
);

    ntt_ctrl_pkg::ntt_state_t state;
    ntt_ctrl_pkg::ite_idx_t   ite_idx;
    logic                     group_end;
    logic                     ite_end;

    butterfly_counter i_counter (
        .clk           (clk),
        .rst           (rst),
        .state         (state),
        .ite_idx       (ite_idx),
        .operand_valid (operand_valid),
        .group_end     (group_end),
        .ite_end       (ite_end)
    );

    stage_sequencer i_sequencer (
        .clk     (clk),
        .rst     (rst),
        .ite_end (ite_end),
        .state   (state),
        .ite_idx (ite_idx)
    );

    control_decoder i_decoder (
        .clk           (clk),
        .rst           (rst),
        .state         (state),
        .ite_idx       (ite_idx),
        .group_end     (group_end),
        .ite_end       (ite_end),
        .operand_valid (operand_valid),
        .read_done     (read_done),
        .bu_done       (bu_done),
        .tf_init_base  (tf_init_base),
        .tf_init_const (tf_init_const),
        .tf_ren        (tf_ren),
        .tf_wen        (tf_wen),
        .tf_depth      (tf_depth),
        .agu_enable    (agu_enable),
        .agu_enable_k2 (agu_enable_k2),
        .r_enable      (r_enable),
        .w_enable      (w_enable),
        .ntt_enable    (ntt_enable),
        .last_stage    (last_stage),
        .finished      (finished)
    );

endmodule

// ==== design/stage_sequencer.sv ====
`timescale 1ns/1ns

module stage_sequencer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     ite_end,
    output ntt_ctrl_pkg::ntt_state_t state,
    output ntt_ctrl_pkg::ite_idx_t   ite_idx
);

    ntt_ctrl_pkg::ntt_state_t state_next;
    ntt_ctrl_pkg::ite_idx_t   idx_next;
    ntt_cfg_pkg::depth_t      init_cnt;
    ntt_cfg_pkg::depth_t      drain_cnt;
    logic                     init_done;
    logic                     drain_done;

    assign init_done  = init_cnt == ntt_cfg_pkg::INIT_CYCLES;
    assign drain_done = drain_cnt == '0;

    // init timer runs only in idle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            init_cnt <= '0;
        end else if (state == ntt_ctrl_pkg::ST_IDLE) begin
            init_cnt <= init_cnt + 1'b1;
        end else begin
            init_cnt <= '0;
        end
    end

    // drain timer, loaded on the final issue and counted down to zero
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            drain_cnt <= '0;
        end else if (state == ntt_ctrl_pkg::ST_ITE && ite_end) begin
            drain_cnt <= ntt_cfg_pkg::DRAIN_LEN[ite_idx] - 1'b1;
        end else if (state == ntt_ctrl_pkg::ST_DRAIN && !drain_done) begin
            drain_cnt <= drain_cnt - 1'b1;
        end
    end

    always_comb begin
        state_next = state;
        idx_next   = ite_idx;
        case (state)
            ntt_ctrl_pkg::ST_RESET: begin
                state_next = ntt_ctrl_pkg::ST_IDLE;
            end
            ntt_ctrl_pkg::ST_IDLE: begin
                if (init_done) begin
                    state_next = ntt_ctrl_pkg::ST_ITE;
                end
            end
            ntt_ctrl_pkg::ST_ITE: begin
                if (ite_end) begin
                    state_next = ntt_ctrl_pkg::ST_DRAIN;
                end
            end
            ntt_ctrl_pkg::ST_DRAIN: begin
                if (drain_done) begin
                    if (ite_idx == ntt_ctrl_pkg::LAST_ITE) begin
                        state_next = ntt_ctrl_pkg::ST_FINISH;
                    end else begin
                        state_next = ntt_ctrl_pkg::ST_ITE;
                        idx_next   = ite_idx + 2'd1;
                    end
                end
            end
            ntt_ctrl_pkg::ST_FINISH: begin
                // parked until the next reset
                state_next = ntt_ctrl_pkg::ST_FINISH;
            end
            default: begin
                state_next = ntt_ctrl_pkg::ST_RESET;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= ntt_ctrl_pkg::ST_RESET;
            ite_idx <= '0;
        end else begin
            state   <= state_next;
            ite_idx <= idx_next;
        end
    end

    a_finish_sticky : assert property (
        @(posedge clk) disable iff (rst)
        (state == ntt_ctrl_pkg::ST_FINISH) |=> (state == ntt_ctrl_pkg::ST_FINISH)
    );

    a_idx_monotonic : assert property (
        @(posedge clk) disable iff (rst)
        1'b1 |=> (ite_idx >= $past(ite_idx))
    );

endmodule

// ==== tb.f ====
design/ntt_cfg_pkg.sv
design/ntt_ctrl_pkg.sv
design/butterfly_counter.sv
design/stage_sequencer.sv
design/control_decoder.sv
design/ntt_ctrl_top.sv
verification/tb_ntt_ctrl.sv

// ==== verification/tb_ntt_ctrl.sv ====
`timescale 1ns/1ns

module tb_ntt_ctrl;

    localparam int CLK_HALF     = 50;
    localparam int RESET_CYCLES = 4;
    localparam int SEED         = 74;
    localparam int VALID_PCT    = 60;
    localparam int FINISH_HOLD  = 8;
    // slowest accepted issue rate is one issue in four cycles
    localparam int MIN_RATE_DIV = 4;
    localparam int BU_SUM       = 3 * int'(ntt_cfg_pkg::BU_TOTAL)
                                + int'(ntt_cfg_pkg::BU_TOTAL_K2);
    localparam int DRAIN_SUM    = int'(ntt_cfg_pkg::DRAIN_LEN[0])
                                + int'(ntt_cfg_pkg::DRAIN_LEN[1])
                                + int'(ntt_cfg_pkg::DRAIN_LEN[2])
                                + int'(ntt_cfg_pkg::DRAIN_LEN[3]);
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 + int'(ntt_cfg_pkg::INIT_CYCLES)
                                   + BU_SUM * MIN_RATE_DIV + DRAIN_SUM + FINISH_HOLD + 16;
    localparam int unsigned DEPTH_PATTERN [4] = '{2, 3, 3, 2};

    logic                clk = 1'b0;
    logic                rst;
    logic                operand_valid;
    logic                read_done;
    logic                bu_done;
    logic                tf_init_base;
    logic                tf_init_const;
    logic                tf_ren;
    logic                tf_wen;
    ntt_cfg_pkg::depth_t tf_depth;
    logic                agu_enable;
    logic                agu_enable_k2;
    logic                r_enable;
    logic                w_enable;
    logic                ntt_enable;
    logic                last_stage;
    logic                finished;

    // reference model
    ntt_ctrl_pkg::ntt_state_t m_state = ntt_ctrl_pkg::ST_RESET;
    int                       m_idx;
    int                       m_cycles;
    int                       m_issued;
    int                       m_grp;
    int                       m_pat;
    logic                     m_issue;
    logic                     m_last_issue;
    logic                     m_grp_done;

    logic        exp_init_base;
    logic        exp_init_const;
    logic        exp_ren;
    logic        exp_wen;
    int unsigned exp_depth;
    logic        exp_agu;
    logic        exp_agu_k2;
    logic        exp_r_enable;
    logic        exp_w_enable;
    logic        exp_ntt_enable;
    logic        exp_last_stage;
    logic        exp_finished;

    int finish_cycles = 0;

    ntt_ctrl_top i_dut (
        .clk           (clk),
        .rst           (rst),
        .operand_valid (operand_valid),
        .read_done     (read_done),
        .bu_done       (bu_done),
        .tf_init_base  (tf_init_base),
        .tf_init_const (tf_init_const),
        .tf_ren        (tf_ren),
        .tf_wen        (tf_wen),
        .tf_depth      (tf_depth),
        .agu_enable    (agu_enable),
        .agu_enable_k2 (agu_enable_k2),
        .r_enable      (r_enable),
        .w_enable      (w_enable),
        .ntt_enable    (ntt_enable),
        .last_stage    (last_stage),
        .finished      (finished)
    );

    always #(CLK_HALF) clk = ~clk;

    function automatic int iteration_total(input int idx);
        if (idx == 3) begin
            return int'(ntt_cfg_pkg::BU_TOTAL_K2);
        end
        return int'(ntt_cfg_pkg::BU_TOTAL);
    endfunction

    task automatic compare_value(input string name, input logic [31:0] actual,
                                 input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("Regression failed");
            $fatal(1, "output mismatch on %s", name);
        end
    endtask

    task automatic drive_inputs();
        operand_valid = ($urandom % 100) < VALID_PCT;
        read_done     = 1'($urandom % 2);
        bu_done       = 1'($urandom % 2);
    endtask

    task automatic start_iteration(input int idx);
        m_state  = ntt_ctrl_pkg::ST_ITE;
        m_idx    = idx;
        m_cycles = 0;
        m_issued = 0;
        m_grp    = 0;
    endtask

    task automatic reset_model();
        m_state  = ntt_ctrl_pkg::ST_RESET;
        m_idx    = 0;
        m_cycles = 0;
        m_issued = 0;
        m_grp    = 0;
        m_pat    = 0;
    endtask

    task automatic compute_expected();
        exp_init_base  = 1'b0;
        exp_init_const = 1'b0;
        exp_ren        = 1'b0;
        exp_wen        = 1'b0;
        exp_depth      = 0;
        exp_agu        = 1'b0;
        exp_agu_k2     = 1'b0;
        exp_r_enable   = 1'b0;
        exp_w_enable   = 1'b0;
        exp_ntt_enable = 1'b0;
        exp_last_stage = 1'b0;
        exp_finished   = 1'b0;
        m_issue        = 1'b0;
        m_last_issue   = 1'b0;
        m_grp_done     = 1'b0;
        case (m_state)
            ntt_ctrl_pkg::ST_IDLE: begin
                exp_init_base  = 1'b1;
                exp_init_const = 1'b1;
            end
            ntt_ctrl_pkg::ST_ITE: begin
                m_issue      = operand_valid;
                m_last_issue = m_issue && (m_issued + 1 == iteration_total(m_idx));
                m_grp_done   = m_issue && (m_grp + 1 == int'(ntt_cfg_pkg::GROUP_LEN[m_idx]));
                exp_r_enable   = m_issue;
                exp_ren        = m_issue;
                exp_w_enable   = bu_done;
                exp_ntt_enable = read_done;
                exp_wen        = (m_idx != 0) && m_grp_done && !m_last_issue;
                if (m_issue) begin
                    if (m_idx == 2) begin
                        exp_depth = DEPTH_PATTERN[m_pat];
                    end else if (m_idx == 3) begin
                        exp_depth = 32'(ntt_cfg_pkg::LAST_DEPTH);
                    end else begin
                        exp_depth = m_idx;
                    end
                end
                if (m_idx == 0) begin
                    exp_agu = m_cycles < int'(ntt_cfg_pkg::AGU_RUN_0);
                end else begin
                    exp_agu = m_idx != 3;
                end
                exp_agu_k2     = m_idx == 3;
                exp_last_stage = m_idx == 3;
            end
            ntt_ctrl_pkg::ST_DRAIN: begin
                exp_w_enable   = 1'b1;
                exp_ntt_enable = read_done;
                exp_depth      = (m_idx == 3) ? 32'(ntt_cfg_pkg::LAST_DEPTH) : m_idx;
                exp_last_stage = m_idx == 3;
            end
            ntt_ctrl_pkg::ST_FINISH: begin
                exp_finished = 1'b1;
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_outputs();
        compare_value("tf_init_base", 32'(tf_init_base), 32'(exp_init_base));
        compare_value("tf_init_const", 32'(tf_init_const), 32'(exp_init_const));
        compare_value("tf_ren", 32'(tf_ren), 32'(exp_ren));
        compare_value("tf_wen", 32'(tf_wen), 32'(exp_wen));
        compare_value("tf_depth", 32'(tf_depth), exp_depth);
        compare_value("agu_enable", 32'(agu_enable), 32'(exp_agu));
        compare_value("agu_enable_k2", 32'(agu_enable_k2), 32'(exp_agu_k2));
        compare_value("r_enable", 32'(r_enable), 32'(exp_r_enable));
        compare_value("w_enable", 32'(w_enable), 32'(exp_w_enable));
        compare_value("ntt_enable", 32'(ntt_enable), 32'(exp_ntt_enable));
        compare_value("last_stage", 32'(last_stage), 32'(exp_last_stage));
        compare_value("finished", 32'(finished), 32'(exp_finished));
    endtask

    task automatic advance_model();
        case (m_state)
            ntt_ctrl_pkg::ST_RESET: begin
                m_state  = ntt_ctrl_pkg::ST_IDLE;
                m_cycles = 0;
            end
            ntt_ctrl_pkg::ST_IDLE: begin
                m_cycles = m_cycles + 1;
                if (m_cycles == int'(ntt_cfg_pkg::INIT_CYCLES) + 1) begin
                    start_iteration(0);
                end
            end
            ntt_ctrl_pkg::ST_ITE: begin
                m_cycles = m_cycles + 1;
                if (m_issue) begin
                    m_issued = m_issued + 1;
                    m_grp    = m_grp_done ? 0 : m_grp + 1;
                    if (m_idx == 2) begin
                        m_pat = (m_pat + 1) % 4;
                    end
                end
                if (m_last_issue) begin
                    m_state  = ntt_ctrl_pkg::ST_DRAIN;
                    m_cycles = 0;
                end
            end
            ntt_ctrl_pkg::ST_DRAIN: begin
                m_cycles = m_cycles + 1;
                if (m_cycles == int'(ntt_cfg_pkg::DRAIN_LEN[m_idx])) begin
                    if (m_idx == 3) begin
                        m_state = ntt_ctrl_pkg::ST_FINISH;
                    end else begin
                        start_iteration(m_idx + 1);
                    end
                end
            end
            default: begin
            end
        endcase
    endtask

    // outputs are sampled before the edge updates any register
    always @(posedge clk) begin
        compute_expected();
        check_outputs();
        if (rst) begin
            reset_model();
        end else begin
            advance_model();
            if (finished) begin
                finish_cycles = finish_cycles + 1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Regression failed");
        $fatal(1, "watchdog expired: finish state not reached within %0d cycles",
               WATCHDOG_CYCLES);
    end

    initial begin
        void'($urandom(SEED));
        rst           = 1'b1;
        operand_valid = 1'b0;
        read_done     = 1'b0;
        bu_done       = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        drive_inputs();
        // keep stimulating in finish to see it hold
        while (finish_cycles < FINISH_HOLD) begin
            @(negedge clk);
            drive_inputs();
        end
        $display("Regression passed");
        $finish;
    end

endmodule
